/* Makefile */
VERILATOR := verilator
TOP       := tb_mem_subsystem
RTL_TOP   := mem_subsystem
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
src/core_pkg.sv
src/dram_model.sv
src/data_cache.sv
src/mem_stage.sv
src/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

/* src/core_pkg.sv */
package core_pkg;

	// data and address widths
	typedef logic [63:0]  word_t;
	typedef logic [63:0]  addr_t;
	typedef logic [127:0] alu_result_t;

	// operand kinds as seen by the memory stage
	typedef enum logic [2:0] {
		oprd_none,
		oprd_reg,
		oprd_imm,
		oprd_mem,
		oprd_stack
	} oprd_kind_t;

	// cache geometry: one 64-bit word per line
	localparam int CACHE_LINES = 16;

	typedef logic [3:0]  cache_index_t;  // addr[6:3]
	typedef logic [56:0] cache_tag_t;    // addr[63:7]

	// backing store
	localparam int DRAM_WORDS   = 1024;  // indexed by addr[12:3], upper bits alias
	localparam int DRAM_LATENCY = 4;     // cycles from request sample to ack

	localparam int DRAM_INDEX_W = $clog2(DRAM_WORDS);
	localparam int DRAM_CNT_W   = $clog2(DRAM_LATENCY + 1);

	typedef logic [DRAM_INDEX_W-1:0] dram_index_t;
	typedef logic [DRAM_CNT_W-1:0]   dram_cnt_t;

	// stack stores land one slot above the stack pointer
	localparam addr_t STACK_SLOT_OFFSET = 64'd8;

endpackage

/* src/data_cache.sv */
`timescale 1ns/10ps

module data_cache (
	input  logic            clk,
	input  logic            rst_n,

	// request from the memory stage
	input  logic            dcache_en,
	input  logic            dcache_wren,
	input  core_pkg::addr_t dcache_addr,
	input  core_pkg::word_t dcache_wdata,
	output core_pkg::word_t dcache_rdata,
	output logic            dcache_done,

	// dram side
	output logic            dram_req,
	output logic            dram_we,
	output core_pkg::addr_t dram_addr,
	output core_pkg::word_t dram_wdata,
	input  core_pkg::word_t dram_rdata,
	input  logic            dram_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_write_through
	} state_t;

	state_t                 state_q;

	core_pkg::word_t        data_q [core_pkg::CACHE_LINES];
	core_pkg::cache_tag_t   tag_q  [core_pkg::CACHE_LINES];
	logic [core_pkg::CACHE_LINES-1:0] valid_q;

	core_pkg::cache_index_t req_index;
	core_pkg::cache_tag_t   req_tag;
	core_pkg::cache_index_t line_index;
	core_pkg::cache_tag_t   line_tag;
	core_pkg::word_t        line_data;

	logic                   hit;
	logic                   accept;
	logic                   rd_hit;
	logic                   rd_miss;
	logic                   wr_req;
	logic                   fill_done;
	logic                   wt_done;
	logic                   line_we;

	assign req_index = dcache_addr[6:3];
	assign req_tag   = dcache_addr[63:7];

	assign hit    = valid_q[req_index] && (tag_q[req_index] == req_tag);
	assign accept = dcache_en && (state_q == st_idle);

	assign rd_hit  = accept && !dcache_wren && hit;
	assign rd_miss = accept && !dcache_wren && !hit;
	assign wr_req  = accept && dcache_wren;

	assign fill_done = (state_q == st_fill) && dram_ack;
	assign wt_done   = (state_q == st_write_through) && dram_ack;

	// a line is written on a store (allocate) or when a fill returns
	// the pending address still sits on dram_addr during the fill
	assign line_we    = wr_req || fill_done;
	assign line_index = fill_done ? dram_addr[6:3] : req_index;
	assign line_tag   = fill_done ? dram_addr[63:7] : req_tag;
	assign line_data  = fill_done ? dram_rdata : dcache_wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= st_idle;
			dram_req    <= 1'b0;
			dcache_done <= 1'b0;
			valid_q     <= '0;
		end else begin
			dram_req    <= rd_miss || wr_req;
			dcache_done <= rd_hit || fill_done || wt_done;

			if (line_we)
				valid_q[line_index] <= 1'b1;

			case (state_q)
				st_idle: begin
					if (rd_miss)
						state_q <= st_fill;
					else if (wr_req)
						state_q <= st_write_through;
				end
				st_fill: begin
					if (dram_ack)
						state_q <= st_idle;
				end
				st_write_through: begin
					if (dram_ack)
						state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// line arrays and dram request fields
	always_ff @(posedge clk) begin
		if (line_we) begin
			data_q[line_index] <= line_data;
			tag_q[line_index]  <= line_tag;
		end

		if (accept) begin
			dram_addr  <= dcache_addr;
			dram_we    <= dcache_wren;
			dram_wdata <= dcache_wdata;
		end

		if (rd_hit)
			dcache_rdata <= data_q[req_index];
		else if (fill_done)
			dcache_rdata <= dram_rdata;  // forward the refilled word
	end

endmodule

/* src/dram_model.sv */
`timescale 1ns/10ps

module dram_model (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            dram_req,
	input  logic            dram_we,
	input  core_pkg::addr_t dram_addr,
	input  core_pkg::word_t dram_wdata,
	output core_pkg::word_t dram_rdata,
	output logic            dram_ack
);

	core_pkg::word_t       mem_q [core_pkg::DRAM_WORDS];

	logic                  busy_q;
	logic                  we_q;
	core_pkg::dram_index_t index_q;
	core_pkg::word_t       wdata_q;
	core_pkg::dram_cnt_t   cnt_q;   // cycles left before the ack
	logic                  finish;

	assign finish = busy_q && (cnt_q == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < core_pkg::DRAM_WORDS; i++)
				mem_q[i] <= '0;
			busy_q   <= 1'b0;
			cnt_q    <= '0;
			dram_ack <= 1'b0;
		end else begin
			dram_ack <= 1'b0;
			if (!busy_q) begin
				if (dram_req) begin
					busy_q <= 1'b1;
					cnt_q  <= core_pkg::dram_cnt_t'(core_pkg::DRAM_LATENCY - 1);
				end
			end else if (finish) begin
				busy_q   <= 1'b0;
				dram_ack <= 1'b1;
				if (we_q)
					mem_q[index_q] <= wdata_q;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// latch the request while idle
	always_ff @(posedge clk) begin
		if (!busy_q && dram_req) begin
			we_q    <= dram_we;
			index_q <= dram_addr[core_pkg::DRAM_INDEX_W+2:3];  // word address
			wdata_q <= dram_wdata;
		end

		if (finish && !we_q)
			dram_rdata <= mem_q[index_q];
	end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
	input  logic                  clk,
	input  logic                  rst_n,

	// micro-op from execute
	input  logic                  enable,
	input  core_pkg::oprd_kind_t  oprd1_kind,
	input  core_pkg::oprd_kind_t  oprd2_kind,
	input  core_pkg::word_t       oprd1_value,
	input  core_pkg::word_t       oprd1_ext,
	input  core_pkg::word_t       oprd2_value,
	input  core_pkg::word_t       oprd2_ext,
	input  core_pkg::alu_result_t alu_result,

	output logic                  mem_blocked,
	output logic                  mem_wb,
	output core_pkg::alu_result_t mem_result,

	// data cache side
	output logic                  dcache_en,
	output logic                  dcache_wren,
	output core_pkg::addr_t       dcache_addr,
	output core_pkg::word_t       dcache_wdata,
	input  core_pkg::word_t       dcache_rdata,
	input  logic                  dcache_done
);

	typedef enum logic {
		st_idle,
		st_waiting
	} state_t;

	state_t                state_q;

	logic                  op_mem;    // micro-op needs the data cache
	logic                  op_store;  // store when set, load otherwise
	core_pkg::addr_t       op_addr;
	logic                  accept;

	logic                  load_q;    // pending request is a load
	core_pkg::alu_result_t alu_result_q;

	// operand decode, oprd1 mem has the highest priority
	always_comb begin
		op_mem   = 1'b1;
		op_store = 1'b0;
		op_addr  = '0;
		if (oprd1_kind == core_pkg::oprd_mem) begin
			op_store = 1'b1;
			op_addr  = oprd1_ext;
		end else if (oprd2_kind == core_pkg::oprd_mem) begin
			op_addr  = oprd2_ext;
		end else if (oprd1_kind == core_pkg::oprd_stack) begin
			op_store = 1'b1;  // push into the slot above sp
			op_addr  = oprd1_value + core_pkg::STACK_SLOT_OFFSET;
		end else if (oprd2_kind == core_pkg::oprd_stack) begin
			op_addr  = oprd2_value;
		end else begin
			op_mem   = 1'b0;  // plain alu op
		end
	end

	assign accept = enable && (state_q == st_idle);

	// stall upstream from acceptance until the cache answers
	assign mem_blocked = (accept && op_mem) ||
		((state_q == st_waiting) && !dcache_done);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= st_idle;
			mem_wb    <= 1'b0;
			dcache_en <= 1'b0;
		end else begin
			mem_wb    <= 1'b0;
			dcache_en <= 1'b0;
			case (state_q)
				st_idle: begin
					if (accept) begin
						if (op_mem) begin
							dcache_en <= 1'b1;
							state_q   <= st_waiting;
						end else begin
							mem_wb <= 1'b1;  // pass-through
						end
					end
				end
				st_waiting: begin
					if (dcache_done) begin
						mem_wb  <= 1'b1;
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// request fields and result
	always_ff @(posedge clk) begin
		if (accept && op_mem) begin
			dcache_wren  <= op_store;
			dcache_addr  <= op_addr;
			dcache_wdata <= alu_result[63:0];  // stores write the low word
			load_q       <= !op_store;
			alu_result_q <= alu_result;
		end

		if (accept && !op_mem) begin
			mem_result <= alu_result;
		end else if ((state_q == st_waiting) && dcache_done) begin
			if (load_q)
				mem_result <= {64'b0, dcache_rdata};
			else
				mem_result <= alu_result_q;
		end
	end

endmodule

/* src/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  enable,
	input  core_pkg::oprd_kind_t  oprd1_kind,
	input  core_pkg::oprd_kind_t  oprd2_kind,
	input  core_pkg::word_t       oprd1_value,
	input  core_pkg::word_t       oprd1_ext,
	input  core_pkg::word_t       oprd2_value,
	input  core_pkg::word_t       oprd2_ext,
	input  core_pkg::alu_result_t alu_result,
	output logic                  mem_blocked,
	output logic                  mem_wb,
	output core_pkg::alu_result_t mem_result
);

	// stage to cache
	logic            dcache_en;
	logic            dcache_wren;
	core_pkg::addr_t dcache_addr;
	core_pkg::word_t dcache_wdata;
	core_pkg::word_t dcache_rdata;
	logic            dcache_done;

	// cache to dram
	logic            dram_req;
	logic            dram_we;
	core_pkg::addr_t dram_addr;
	core_pkg::word_t dram_wdata;
	core_pkg::word_t dram_rdata;
	logic            dram_ack;

	mem_stage u_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.oprd1_kind   (oprd1_kind),
		.oprd2_kind   (oprd2_kind),
		.oprd1_value  (oprd1_value),
		.oprd1_ext    (oprd1_ext),
		.oprd2_value  (oprd2_value),
		.oprd2_ext    (oprd2_ext),
		.alu_result   (alu_result),
		.mem_blocked  (mem_blocked),
		.mem_wb       (mem_wb),
		.mem_result   (mem_result),
		.dcache_en    (dcache_en),
		.dcache_wren  (dcache_wren),
		.dcache_addr  (dcache_addr),
		.dcache_wdata (dcache_wdata),
		.dcache_rdata (dcache_rdata),
		.dcache_done  (dcache_done)
	);

	data_cache u_data_cache (
		.clk          (clk),
		.rst_n        (rst_n),
		.dcache_en    (dcache_en),
		.dcache_wren  (dcache_wren),
		.dcache_addr  (dcache_addr),
		.dcache_wdata (dcache_wdata),
		.dcache_rdata (dcache_rdata),
		.dcache_done  (dcache_done),
		.dram_req     (dram_req),
		.dram_we      (dram_we),
		.dram_addr    (dram_addr),
		.dram_wdata   (dram_wdata),
		.dram_rdata   (dram_rdata),
		.dram_ack     (dram_ack)
	);

	dram_model u_dram_model (
		.clk        (clk),
		.rst_n      (rst_n),
		.dram_req   (dram_req),
		.dram_we    (dram_we),
		.dram_addr  (dram_addr),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata),
		.dram_ack   (dram_ack)
	);

endmodule

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/10ps

module tb_mem_subsystem;

	logic                  clk;
	logic                  rst_n;
	logic                  enable;
	core_pkg::oprd_kind_t  oprd1_kind;
	core_pkg::oprd_kind_t  oprd2_kind;
	core_pkg::word_t       oprd1_value;
	core_pkg::word_t       oprd1_ext;
	core_pkg::word_t       oprd2_value;
	core_pkg::word_t       oprd2_ext;
	core_pkg::alu_result_t alu_result;
	logic                  mem_blocked;
	logic                  mem_wb;
	core_pkg::alu_result_t mem_result;

	// stimulus table, one entry per micro-op
	core_pkg::oprd_kind_t  tbl_kind1 [$];
	core_pkg::oprd_kind_t  tbl_kind2 [$];
	core_pkg::word_t       tbl_v1 [$];
	core_pkg::word_t       tbl_e1 [$];
	core_pkg::word_t       tbl_v2 [$];
	core_pkg::word_t       tbl_e2 [$];
	core_pkg::alu_result_t tbl_alu [$];
	core_pkg::alu_result_t tbl_exp [$];
	logic                  tbl_mem [$];  // row goes through the data cache
	int                    tbl_lat [$];  // cycles from accepting cycle to mem_wb, 0 = any

	core_pkg::word_t       ref_mem [core_pkg::DRAM_WORDS];  // expected dram contents
	logic [31:0]           lcg_state;

	mem_subsystem u_mem_subsystem (
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.oprd1_kind  (oprd1_kind),
		.oprd2_kind  (oprd2_kind),
		.oprd1_value (oprd1_value),
		.oprd1_ext   (oprd1_ext),
		.oprd2_value (oprd2_value),
		.oprd2_ext   (oprd2_ext),
		.alu_result  (alu_result),
		.mem_blocked (mem_blocked),
		.mem_wb      (mem_wb),
		.mem_result  (mem_result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic core_pkg::word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi, lo};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_result(input string name, input core_pkg::alu_result_t got,
		input core_pkg::alu_result_t exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("** Error: mem_wb latency got 0x%h expected 0x%h", got, exp));
	endtask

	// expected result follows the operand priority and the mem_result rule
	task automatic add_row(
		input core_pkg::oprd_kind_t k1,
		input core_pkg::oprd_kind_t k2,
		input core_pkg::word_t      v1,
		input core_pkg::word_t      e1,
		input core_pkg::word_t      v2,
		input core_pkg::word_t      e2,
		input int                   lat
	);
		core_pkg::alu_result_t alu;
		core_pkg::alu_result_t exp;
		core_pkg::addr_t       addr;
		logic                  is_mem;
		logic                  is_store;
		alu      = {rand_word(), rand_word()};
		is_mem   = 1'b1;
		is_store = 1'b0;
		addr     = '0;
		if (k1 == core_pkg::oprd_mem) begin
			is_store = 1'b1;
			addr     = e1;
		end else if (k2 == core_pkg::oprd_mem) begin
			addr = e2;
		end else if (k1 == core_pkg::oprd_stack) begin
			is_store = 1'b1;
			addr     = v1 + core_pkg::STACK_SLOT_OFFSET;
		end else if (k2 == core_pkg::oprd_stack) begin
			addr = v2;
		end else begin
			is_mem = 1'b0;
		end
		if (!is_mem) begin
			exp = alu;
		end else if (is_store) begin
			ref_mem[addr[12:3]] = alu[63:0];
			exp = alu;
		end else begin
			exp = {64'b0, ref_mem[addr[12:3]]};
		end
		tbl_kind1.push_back(k1);
		tbl_kind2.push_back(k2);
		tbl_v1.push_back(v1);
		tbl_e1.push_back(e1);
		tbl_v2.push_back(v2);
		tbl_e2.push_back(e2);
		tbl_alu.push_back(alu);
		tbl_exp.push_back(exp);
		tbl_mem.push_back(is_mem);
		tbl_lat.push_back(lat);
	endtask

	task automatic build_table();
		core_pkg::addr_t addr_a;
		core_pkg::addr_t addr_fresh;
		core_pkg::addr_t sp;
		core_pkg::addr_t line_b;
		core_pkg::addr_t line_c;
		addr_a     = 64'h0000_0000_0000_1238;
		addr_fresh = 64'h0000_0000_0000_02a8;  // never written
		sp         = 64'h0000_0000_0000_03f0;
		line_b     = 64'h0000_0000_0000_0480;  // index 0, tag 0x09
		line_c     = 64'h0000_0000_0000_1880;  // index 0, tag 0x31

		// pass-through
		add_row(core_pkg::oprd_reg, core_pkg::oprd_reg,
			rand_word(), rand_word(), rand_word(), rand_word(), 1);
		add_row(core_pkg::oprd_imm, core_pkg::oprd_none,
			rand_word(), rand_word(), rand_word(), rand_word(), 1);
		add_row(core_pkg::oprd_none, core_pkg::oprd_imm,
			rand_word(), rand_word(), rand_word(), rand_word(), 1);

		// store then load, the store allocates so the load hits
		add_row(core_pkg::oprd_mem, core_pkg::oprd_reg,
			rand_word(), addr_a, rand_word(), rand_word(), 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), addr_a, 3);
		add_row(core_pkg::oprd_imm, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), addr_fresh, 0);
		add_row(core_pkg::oprd_imm, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), addr_fresh, 3);

		// stack slot above sp, with older content at sp itself
		add_row(core_pkg::oprd_mem, core_pkg::oprd_none,
			rand_word(), sp, rand_word(), rand_word(), 0);
		add_row(core_pkg::oprd_stack, core_pkg::oprd_reg,
			sp, rand_word(), rand_word(), rand_word(), 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_stack,
			rand_word(), rand_word(), sp + 64'd8, rand_word(), 3);
		add_row(core_pkg::oprd_none, core_pkg::oprd_stack,
			rand_word(), rand_word(), sp, rand_word(), 3);

		// oprd2 mem outranks oprd1 stack
		add_row(core_pkg::oprd_stack, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), addr_a, 3);

		// two tags fighting over line 0
		add_row(core_pkg::oprd_mem, core_pkg::oprd_mem,
			rand_word(), line_b, rand_word(), line_c, 0);
		add_row(core_pkg::oprd_mem, core_pkg::oprd_reg,
			rand_word(), line_c, rand_word(), rand_word(), 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), line_b, 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), line_c, 0);
		add_row(core_pkg::oprd_mem, core_pkg::oprd_imm,
			rand_word(), line_b, rand_word(), rand_word(), 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), line_c, 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), line_b, 0);
		add_row(core_pkg::oprd_reg, core_pkg::oprd_mem,
			rand_word(), rand_word(), rand_word(), line_b, 3);

		add_row(core_pkg::oprd_reg, core_pkg::oprd_imm,
			rand_word(), rand_word(), rand_word(), rand_word(), 1);
	endtask

	task automatic apply_row(input int i);
		int   cycles;
		logic blocked_prev;
		logic done;
		@(posedge clk);
		#1;
		oprd1_kind  = tbl_kind1[i];
		oprd2_kind  = tbl_kind2[i];
		oprd1_value = tbl_v1[i];
		oprd1_ext   = tbl_e1[i];
		oprd2_value = tbl_v2[i];
		oprd2_ext   = tbl_e2[i];
		alu_result  = tbl_alu[i];
		enable      = 1'b1;
		@(negedge clk);
		check_bit("mem_blocked", mem_blocked, tbl_mem[i]);  // accepting cycle
		check_bit("mem_wb", mem_wb, 1'b0);
		blocked_prev = mem_blocked;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clk);
			#1;
			cycles++;
			// enable stays up in every busy cycle, dropped once mem_wb is up
			enable = tbl_mem[i] && !mem_wb;
			@(negedge clk);
			if (mem_wb) begin
				check_bit("mem_blocked", blocked_prev, 1'b0);
				check_result("mem_result", mem_result, tbl_exp[i]);
				done = 1'b1;
			end else begin
				check_bit("mem_blocked", blocked_prev, 1'b1);
				if (cycles >= 100)
					abort_run($sformatf("timeout waiting for mem_wb on row %0d", i));
			end
			blocked_prev = mem_blocked;
		end
		if (tbl_lat[i] != 0)
			check_latency(cycles, tbl_lat[i]);
	endtask

	initial begin
		rst_n       = 1'b0;
		enable      = 1'b0;
		oprd1_kind  = core_pkg::oprd_none;
		oprd2_kind  = core_pkg::oprd_none;
		oprd1_value = '0;
		oprd1_ext   = '0;
		oprd2_value = '0;
		oprd2_ext   = '0;
		alu_result  = '0;
		lcg_state   = 32'hf560e549;
		for (int i = 0; i < core_pkg::DRAM_WORDS; i++)
			ref_mem[i] = '0;
		build_table();

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < tbl_alu.size(); i++)
			apply_row(i);

		// no late mem_wb after the last row
		@(posedge clk);
		#1;
		enable = 1'b0;
		@(negedge clk);
		check_bit("mem_wb", mem_wb, 1'b0);

		$display("Simulation PASSED");
		$finish;
	end

endmodule
